// ==== llander_glue.f ====
src/llander_input_pkg.sv
src/llander_sys_pkg.sv
src/key_decoder.sv
src/lander_controls.sv
src/rom_loader.sv
src/difficulty_hold.sv
src/audio_dac.sv
src/llander_glue_top.sv
+incdir+testbench
testbench/tb_llander_glue.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_llander_glue \
	-f llander_glue.f -o tb_llander_glue || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_llander_glue)
echo "$out"
echo "$out" | grep -qx "Simulation PASSED" && exit 0 || exit 1

// ==== src/audio_dac.sv ====
`timescale 1ns/1ns

module audio_dac #(
	parameter int DAC_BITS = 8
) (
	input  logic                i_clk_25,
	input  logic                i_arst_n,
	input  logic [DAC_BITS-1:0] i_audio,
	output logic                o_audio
);
	// residue in the low bits, carry on top
	logic [DAC_BITS:0] acc;

	always_ff @(posedge i_clk_25 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[DAC_BITS-1:0]} + {1'b0, i_audio};
		end
	end

	assign o_audio = acc[DAC_BITS]; // pulse density follows the sample

endmodule

// ==== src/difficulty_hold.sv ====
`timescale 1ns/1ns

module difficulty_hold #(
	parameter int unsigned DIFF_HOLD = 250_000_000
) (
	input  logic       i_clk_25,
	input  logic       i_arst_n,
	input  logic       i_abort_pressed,
	input  logic       i_lamp3,
	input  logic       i_lamp4,
	input  logic       i_lamp5,
	output logic       o_diff_show,
	output logic [1:0] o_difficulty
);
	localparam int HOLD_W = $clog2(DIFF_HOLD + 1);

	logic [HOLD_W-1:0] hold_cnt;

	always_ff @(posedge i_clk_25 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			hold_cnt <= '0;
		end else if (i_abort_pressed) begin
			hold_cnt <= HOLD_W'(DIFF_HOLD); // restart while held
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	assign o_diff_show = hold_cnt != '0;

	// highest lit lamp wins
	always_comb begin
		if (i_lamp5)
			o_difficulty = 2'd3;
		else if (i_lamp4)
			o_difficulty = 2'd2;
		else if (i_lamp3)
			o_difficulty = 2'd1;
		else
			o_difficulty = 2'd0;
	end

	a_hold_bound: assert property (@(posedge i_clk_25) disable iff (!i_arst_n)
		hold_cnt <= HOLD_W'(DIFF_HOLD));

endmodule

// ==== src/key_decoder.sv ====
`timescale 1ns/1ns

module key_decoder (
	input  logic                                i_clk_25,
	input  logic                                i_arst_n,
	input  logic                                i_key_strobe,
	input  logic                                i_key_pressed,
	input  logic [llander_input_pkg::KEY_W-1:0] i_key_code,
	output logic                                o_btn_up,
	output logic                                o_btn_down,
	output logic                                o_btn_left,
	output logic                                o_btn_right,
	output logic                                o_btn_coin,
	output logic                                o_btn_start,
	output logic                                o_btn_fire1,
	output logic                                o_btn_fire2
);
	import llander_input_pkg::*;

	logic      strobe_q;
	logic      key_event;
	key_code_e code;

	assign key_event = i_key_strobe != strobe_q; // strobe is a toggle
	assign code = key_code_e'(i_key_code);

	always_ff @(posedge i_clk_25 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			strobe_q    <= 1'b0;
			o_btn_up    <= 1'b0;
			o_btn_down  <= 1'b0;
			o_btn_left  <= 1'b0;
			o_btn_right <= 1'b0;
			o_btn_coin  <= 1'b0;
			o_btn_start <= 1'b0;
			o_btn_fire1 <= 1'b0;
			o_btn_fire2 <= 1'b0;
		end else begin
			strobe_q <= i_key_strobe;
			if (key_event) begin
				case (code)
					KEY_UP:    o_btn_up    <= i_key_pressed;
					KEY_DOWN:  o_btn_down  <= i_key_pressed;
					KEY_LEFT:  o_btn_left  <= i_key_pressed;
					KEY_RIGHT: o_btn_right <= i_key_pressed;
					KEY_ESC:   o_btn_coin  <= i_key_pressed;
					KEY_F1:    o_btn_start <= i_key_pressed;
					KEY_SPACE: o_btn_fire1 <= i_key_pressed;
					KEY_ALT:   o_btn_fire2 <= i_key_pressed;
					default: ; // other keys are not wired to the cabinet
				endcase
			end
		end
	end

	// buttons only move on a key event
	a_btn_needs_event: assert property (@(posedge i_clk_25) disable iff (!i_arst_n)
		!key_event |=> $stable({o_btn_up, o_btn_down, o_btn_left, o_btn_right,
			o_btn_coin, o_btn_start, o_btn_fire1, o_btn_fire2}));

endmodule

// ==== src/lander_controls.sv ====
`timescale 1ns/1ns

module lander_controls #(
	parameter int unsigned THRUST_TICK = 98_425
) (
	input  logic                                   i_clk_25,
	input  logic                                   i_arst_n,
	input  logic                                   i_btn_up,
	input  logic                                   i_btn_down,
	input  logic                                   i_btn_left,
	input  logic                                   i_btn_right,
	input  logic                                   i_btn_coin,
	input  logic                                   i_btn_start,
	input  logic                                   i_btn_fire1,
	input  logic                                   i_btn_fire2,
	input  logic [llander_input_pkg::JOY_W-1:0]    i_joy0,
	input  logic [llander_input_pkg::JOY_W-1:0]    i_joy1,
	output logic                                   o_rot_left_n,
	output logic                                   o_rot_right_n,
	output logic                                   o_abort_n,
	output logic                                   o_game_sel_n,
	output logic                                   o_start_n,
	output logic                                   o_coin_n,
	output logic [llander_input_pkg::THRUST_W-1:0] o_thrust,
	output logic                                   o_abort_pressed
);
	import llander_input_pkg::*;

	localparam int TICK_W = $clog2(THRUST_TICK + 1);

	logic              m_up;
	logic              m_down;
	logic              m_left;
	logic              m_right;
	logic              m_fire1;
	logic              m_fire2;
	logic [TICK_W-1:0] tick_cnt;
	logic              tick_wrap;

	// keyboard or either stick
	assign m_up    = i_btn_up    | i_joy0[JOY_UP]    | i_joy1[JOY_UP];
	assign m_down  = i_btn_down  | i_joy0[JOY_DOWN]  | i_joy1[JOY_DOWN];
	assign m_left  = i_btn_left  | i_joy0[JOY_LEFT]  | i_joy1[JOY_LEFT];
	assign m_right = i_btn_right | i_joy0[JOY_RIGHT] | i_joy1[JOY_RIGHT];
	assign m_fire1 = i_btn_fire1 | i_joy0[JOY_FIRE1] | i_joy1[JOY_FIRE1];
	assign m_fire2 = i_btn_fire2 | i_joy0[JOY_FIRE2] | i_joy1[JOY_FIRE2];

	assign o_rot_left_n    = ~m_left;
	assign o_rot_right_n   = ~m_right;
	assign o_abort_n       = ~m_fire2;
	assign o_game_sel_n    = ~m_fire1;
	assign o_start_n       = ~i_btn_start; // keyboard only
	assign o_coin_n        = ~i_btn_coin;
	assign o_abort_pressed = m_fire2;

	assign tick_wrap = tick_cnt == TICK_W'(THRUST_TICK - 1);

	always_ff @(posedge i_clk_25 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			tick_cnt <= '0;
			o_thrust <= '0;
		end else begin
			tick_cnt <= tick_wrap ? '0 : tick_cnt + 1'b1;
			if (tick_wrap) begin
				// up takes priority over down
				if (m_up) begin
					if (o_thrust < THRUST_MAX)
						o_thrust <= o_thrust + 1'b1;
				end else if (m_down && o_thrust != '0) begin
					o_thrust <= o_thrust - 1'b1;
				end
			end
		end
	end

	a_thrust_ceiling: assert property (@(posedge i_clk_25) disable iff (!i_arst_n)
		o_thrust <= THRUST_MAX);

endmodule

// ==== src/llander_glue_top.sv ====
`timescale 1ns/1ns

module llander_glue_top #(
	parameter int unsigned THRUST_TICK = 98_425,
	parameter int unsigned DIFF_HOLD   = 250_000_000,
	parameter int          DAC_BITS    = 8
) (
	input  logic                                   i_clk_25,
	input  logic                                   i_arst_n,
	input  logic                                   i_key_strobe,
	input  logic                                   i_key_pressed,
	input  logic [llander_input_pkg::KEY_W-1:0]    i_key_code,
	input  logic [llander_input_pkg::JOY_W-1:0]    i_joy0,
	input  logic [llander_input_pkg::JOY_W-1:0]    i_joy1,
	input  logic                                   i_ioctl_download,
	input  logic                                   i_ioctl_wr,
	input  logic [llander_sys_pkg::IOCTL_AW-1:0]   i_ioctl_addr,
	input  logic [7:0]                             i_ioctl_dout,
	input  logic                                   i_menu_reset,
	input  logic                                   i_button_reset,
	input  logic [llander_sys_pkg::ROM_AW-1:0]     i_cpu_rom_addr,
	input  logic [llander_sys_pkg::ROM_AW-1:0]     i_vector_rom_addr,
	input  logic [llander_sys_pkg::MEM_DW-1:0]     i_cpu_mem_q,
	input  logic [llander_sys_pkg::MEM_DW-1:0]     i_vector_mem_q,
	input  logic                                   i_lamp3,
	input  logic                                   i_lamp4,
	input  logic                                   i_lamp5,
	input  logic [DAC_BITS-1:0]                    i_audio,
	output logic                                   o_rot_left_n,
	output logic                                   o_rot_right_n,
	output logic                                   o_abort_n,
	output logic                                   o_game_sel_n,
	output logic                                   o_start_n,
	output logic                                   o_coin_n,
	output logic [llander_input_pkg::THRUST_W-1:0] o_thrust,
	output logic                                   o_port1_req,
	output logic                                   o_port2_req,
	output logic [llander_sys_pkg::MEM_AW-1:0]     o_port1_addr,
	output logic [llander_sys_pkg::MEM_AW-1:0]     o_port2_addr,
	output logic [1:0]                             o_port_ds,
	output logic                                   o_port_we,
	output logic [llander_sys_pkg::MEM_DW-1:0]     o_port_d,
	output logic [llander_sys_pkg::RD_AW-1:0]      o_cpu_mem_addr,
	output logic [llander_sys_pkg::RD_AW-1:0]      o_vector_mem_addr,
	output logic [7:0]                             o_cpu_rom_data,
	output logic [7:0]                             o_vector_rom_data,
	output logic                                   o_core_reset,
	output logic                                   o_led,
	output logic                                   o_diff_show,
	output logic [1:0]                             o_difficulty,
	output logic                                   o_audio
);
	logic btn_up;
	logic btn_down;
	logic btn_left;
	logic btn_right;
	logic btn_coin;
	logic btn_start;
	logic btn_fire1;
	logic btn_fire2;
	logic abort_pressed;

	key_decoder u_key_decoder (
		.i_clk_25      (i_clk_25),
		.i_arst_n      (i_arst_n),
		.i_key_strobe  (i_key_strobe),
		.i_key_pressed (i_key_pressed),
		.i_key_code    (i_key_code),
		.o_btn_up      (btn_up),
		.o_btn_down    (btn_down),
		.o_btn_left    (btn_left),
		.o_btn_right   (btn_right),
		.o_btn_coin    (btn_coin),
		.o_btn_start   (btn_start),
		.o_btn_fire1   (btn_fire1),
		.o_btn_fire2   (btn_fire2)
	);

	lander_controls #(
		.THRUST_TICK (THRUST_TICK)
	) u_lander_controls (
		.i_clk_25        (i_clk_25),
		.i_arst_n        (i_arst_n),
		.i_btn_up        (btn_up),
		.i_btn_down      (btn_down),
		.i_btn_left      (btn_left),
		.i_btn_right     (btn_right),
		.i_btn_coin      (btn_coin),
		.i_btn_start     (btn_start),
		.i_btn_fire1     (btn_fire1),
		.i_btn_fire2     (btn_fire2),
		.i_joy0          (i_joy0),
		.i_joy1          (i_joy1),
		.o_rot_left_n    (o_rot_left_n),
		.o_rot_right_n   (o_rot_right_n),
		.o_abort_n       (o_abort_n),
		.o_game_sel_n    (o_game_sel_n),
		.o_start_n       (o_start_n),
		.o_coin_n        (o_coin_n),
		.o_thrust        (o_thrust),
		.o_abort_pressed (abort_pressed)
	);

	rom_loader u_rom_loader (
		.i_clk_25          (i_clk_25),
		.i_arst_n          (i_arst_n),
		.i_ioctl_download  (i_ioctl_download),
		.i_ioctl_wr        (i_ioctl_wr),
		.i_ioctl_addr      (i_ioctl_addr),
		.i_ioctl_dout      (i_ioctl_dout),
		.i_menu_reset      (i_menu_reset),
		.i_button_reset    (i_button_reset),
		.i_cpu_rom_addr    (i_cpu_rom_addr),
		.i_vector_rom_addr (i_vector_rom_addr),
		.i_cpu_mem_q       (i_cpu_mem_q),
		.i_vector_mem_q    (i_vector_mem_q),
		.o_port1_req       (o_port1_req),
		.o_port2_req       (o_port2_req),
		.o_port1_addr      (o_port1_addr),
		.o_port2_addr      (o_port2_addr),
		.o_port_ds         (o_port_ds),
		.o_port_we         (o_port_we),
		.o_port_d          (o_port_d),
		.o_cpu_mem_addr    (o_cpu_mem_addr),
		.o_vector_mem_addr (o_vector_mem_addr),
		.o_cpu_rom_data    (o_cpu_rom_data),
		.o_vector_rom_data (o_vector_rom_data),
		.o_core_reset      (o_core_reset),
		.o_led             (o_led)
	);

	difficulty_hold #(
		.DIFF_HOLD (DIFF_HOLD)
	) u_difficulty_hold (
		.i_clk_25        (i_clk_25),
		.i_arst_n        (i_arst_n),
		.i_abort_pressed (abort_pressed),
		.i_lamp3         (i_lamp3),
		.i_lamp4         (i_lamp4),
		.i_lamp5         (i_lamp5),
		.o_diff_show     (o_diff_show),
		.o_difficulty    (o_difficulty)
	);

	audio_dac #(
		.DAC_BITS (DAC_BITS)
	) u_audio_dac (
		.i_clk_25 (i_clk_25),
		.i_arst_n (i_arst_n),
		.i_audio  (i_audio),
		.o_audio  (o_audio)
	);

endmodule

// ==== src/llander_input_pkg.sv ====
package llander_input_pkg;

	// keyboard and joystick bus widths
	localparam int KEY_W = 8;
	localparam int JOY_W = 8;

	// thrust level bus and its ceiling
	localparam int THRUST_W = 8;
	localparam logic [THRUST_W-1:0] THRUST_MAX = THRUST_W'(254);

	// joystick bit positions, same on both sticks
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE1 = 4;
	localparam int JOY_FIRE2 = 5;

	// ps/2 set 2 scan codes used by the cabinet
	typedef enum logic [KEY_W-1:0] {
		KEY_F1    = 8'h05, // one player start
		KEY_ALT   = 8'h11, // fire2, abort
		KEY_SPACE = 8'h29, // fire1, game select
		KEY_LEFT  = 8'h6b,
		KEY_DOWN  = 8'h72,
		KEY_RIGHT = 8'h74,
		KEY_UP    = 8'h75,
		KEY_ESC   = 8'h76  // coin
	} key_code_e;

endpackage

// ==== src/llander_sys_pkg.sv ====
package llander_sys_pkg;

	// rom download progress
	typedef enum logic [1:0] {
		LD_EMPTY       = 2'd0,
		LD_DOWNLOADING = 2'd1,
		LD_LOADED      = 2'd2
	} load_state_e;

	// ioctl byte address from the data receiver
	localparam int IOCTL_AW = 25;

	// memory request ports, word addressed
	localparam int MEM_AW = 23;
	localparam int MEM_DW = 16;

	// core rom byte address and memory read address widths
	localparam int ROM_AW = 13;
	localparam int RD_AW  = 15;

	// read address while the download owns the memory
	localparam logic [RD_AW-1:0] READ_PARK = 15'h7fff;

	// sound board image sits this many words above the cpu image
	localparam logic [MEM_AW-1:0] PORT2_OFFSET = MEM_AW'('h1000);

endpackage

// ==== src/rom_loader.sv ====
`timescale 1ns/1ns

module rom_loader (
	input  logic                                  i_clk_25,
	input  logic                                  i_arst_n,
	input  logic                                  i_ioctl_download,
	input  logic                                  i_ioctl_wr,
	input  logic [llander_sys_pkg::IOCTL_AW-1:0]  i_ioctl_addr,
	input  logic [7:0]                            i_ioctl_dout,
	input  logic                                  i_menu_reset,
	input  logic                                  i_button_reset,
	input  logic [llander_sys_pkg::ROM_AW-1:0]    i_cpu_rom_addr,
	input  logic [llander_sys_pkg::ROM_AW-1:0]    i_vector_rom_addr,
	input  logic [llander_sys_pkg::MEM_DW-1:0]    i_cpu_mem_q,
	input  logic [llander_sys_pkg::MEM_DW-1:0]    i_vector_mem_q,
	output logic                                  o_port1_req,
	output logic                                  o_port2_req,
	output logic [llander_sys_pkg::MEM_AW-1:0]    o_port1_addr,
	output logic [llander_sys_pkg::MEM_AW-1:0]    o_port2_addr,
	output logic [1:0]                            o_port_ds,
	output logic                                  o_port_we,
	output logic [llander_sys_pkg::MEM_DW-1:0]    o_port_d,
	output logic [llander_sys_pkg::RD_AW-1:0]     o_cpu_mem_addr,
	output logic [llander_sys_pkg::RD_AW-1:0]     o_vector_mem_addr,
	output logic [7:0]                            o_cpu_rom_data,
	output logic [7:0]                            o_vector_rom_data,
	output logic                                  o_core_reset,
	output logic                                  o_led
);
	import llander_sys_pkg::*;

	logic        wr_q;
	logic        download_q;
	load_state_e load_state;

	// word address and lane select straight from the byte address
	assign o_port1_addr = i_ioctl_addr[MEM_AW:1];
	assign o_port2_addr = i_ioctl_addr[MEM_AW:1] - PORT2_OFFSET;
	assign o_port_ds    = {i_ioctl_addr[0], ~i_ioctl_addr[0]};
	assign o_port_we    = i_ioctl_download;
	assign o_port_d     = {i_ioctl_dout, i_ioctl_dout};

	assign o_cpu_mem_addr    = i_ioctl_download ? READ_PARK
		: RD_AW'(i_cpu_rom_addr[ROM_AW-1:1]);
	assign o_vector_mem_addr = i_ioctl_download ? READ_PARK
		: RD_AW'(i_vector_rom_addr[ROM_AW-1:1]);

	assign o_cpu_rom_data    = i_cpu_rom_addr[0] ? i_cpu_mem_q[15:8] : i_cpu_mem_q[7:0];
	assign o_vector_rom_data = i_vector_rom_addr[0] ? i_vector_mem_q[15:8]
		: i_vector_mem_q[7:0];

	assign o_led = ~i_ioctl_download;

	always_ff @(posedge i_clk_25 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_q         <= 1'b0;
			download_q   <= 1'b0;
			o_port1_req  <= 1'b0;
			o_port2_req  <= 1'b0;
			load_state   <= LD_EMPTY;
			o_core_reset <= 1'b1;
		end else begin
			wr_q       <= i_ioctl_wr;
			download_q <= i_ioctl_download;
			if (i_ioctl_download && i_ioctl_wr && !wr_q) begin
				o_port1_req <= ~o_port1_req; // one toggle per byte
				o_port2_req <= ~o_port2_req;
			end
			case (load_state)
				LD_EMPTY:       if (i_ioctl_download) load_state <= LD_DOWNLOADING;
				LD_DOWNLOADING: if (download_q && !i_ioctl_download) load_state <= LD_LOADED;
				default:        load_state <= LD_LOADED;
			endcase
			o_core_reset <= i_menu_reset | i_button_reset | (load_state != LD_LOADED);
		end
	end

	a_req_pair: assert property (@(posedge i_clk_25) disable iff (!i_arst_n)
		o_port1_req == o_port2_req);

	// once loaded the core never goes back to waiting
	a_loaded_sticks: assert property (@(posedge i_clk_25) disable iff (!i_arst_n)
		load_state == LD_LOADED |=> load_state == LD_LOADED);

endmodule

// ==== testbench/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// n clocks, inputs change just after the edge
task automatic step(input int n);
	repeat (n) @(posedge clk_25);
	#1;
endtask

task automatic press_key(input logic [7:0] code, input logic pressed);
	key_code = code;
	key_pressed = pressed;
	key_strobe = ~key_strobe; // one event per toggle
	step(1);
endtask

function automatic logic [7:0] pick_unmapped();
	logic [7:0] code;
	code = 8'($urandom);
	while (code inside {KEY_UP, KEY_DOWN, KEY_LEFT, KEY_RIGHT, KEY_ESC, KEY_F1,
		KEY_SPACE, KEY_ALT})
		code = code + 8'd1;
	return code;
endfunction

task automatic write_byte(input logic [24:0] addr, input logic [7:0] data);
	ioctl_addr = addr;
	ioctl_dout = data;
	ioctl_wr = 1'b1;
	step(1);
	ioctl_wr = 1'b0;
	step(1);
endtask

task automatic check_thrust(input logic [7:0] want);
	if (o_thrust != want) begin
		errors++;
		$display("MISMATCH at %0t: thrust %0d, expected %0d", $time, o_thrust, want);
	end
endtask

task automatic wait_thrust(input logic [7:0] target, input int limit);
	int n;
	n = 0;
	while (o_thrust != target && n < limit) begin
		step(1);
		n++;
	end
	if (o_thrust != target) begin
		errors++;
		$display("timeout: thrust never reached %0d in %0d cycles", target, limit);
	end
endtask

task automatic wait_core_reset_low(input int limit);
	int n;
	n = 0;
	while (o_core_reset && n < limit) begin
		step(1);
		n++;
	end
	if (o_core_reset) begin
		errors++;
		$display("timeout: core reset still high after the download ended");
	end
endtask

task automatic wait_overlay_off(input int limit, output int cycles);
	cycles = 0;
	while (o_diff_show && cycles < limit) begin
		step(1);
		cycles++;
	end
	if (o_diff_show) begin
		errors++;
		$display("timeout: difficulty overlay never switched off");
	end
endtask

// count ones over one full accumulator period
task automatic measure_audio(input logic [7:0] value);
	int ones;
	audio = value;
	step(4);
	ones = 0;
	repeat (256) begin
		step(1);
		if (o_audio)
			ones++;
	end
	if (ones < int'(value) - 1 || ones > int'(value) + 1) begin
		errors++;
		$display("MISMATCH at %0t: audio %0d gave %0d ones", $time, value, ones);
	end
endtask

task automatic report_test(input string name, input int errors_before);
	tests_run++;
	if (errors == errors_before) begin
		$display("test %s: ok", name);
	end else begin
		tests_failed++;
		$display("test %s: %0d errors", name, errors - errors_before);
	end
endtask

`endif

// ==== testbench/tb_llander_glue.sv ====
`timescale 1ns/1ns

module tb_llander_glue;
	import llander_input_pkg::*;

	localparam int unsigned TICK = 8;
	localparam int unsigned HOLD = 40;

	logic        clk_25;
	logic        arst_n;
	logic        key_strobe;
	logic        key_pressed;
	logic [7:0]  key_code;
	logic [7:0]  joy0;
	logic [7:0]  joy1;
	logic        ioctl_download;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic        menu_reset;
	logic        button_reset;
	logic [12:0] cpu_rom_addr;
	logic [12:0] vector_rom_addr;
	logic [15:0] cpu_mem_q;
	logic [15:0] vector_mem_q;
	logic        lamp3;
	logic        lamp4;
	logic        lamp5;
	logic [7:0]  audio;

	logic        o_rot_left_n, o_rot_right_n, o_abort_n, o_game_sel_n, o_start_n, o_coin_n;
	logic [7:0]  o_thrust;
	logic        o_port1_req, o_port2_req, o_port_we, o_core_reset, o_led;
	logic [22:0] o_port1_addr, o_port2_addr;
	logic [1:0]  o_port_ds;
	logic [15:0] o_port_d;
	logic [14:0] o_cpu_mem_addr, o_vector_mem_addr;
	logic [7:0]  o_cpu_rom_data, o_vector_rom_data;
	logic        o_diff_show;
	logic [1:0]  o_difficulty;
	logic        o_audio;

	int errors;
	int tests_run;
	int tests_failed;

	// reference state built from the interface rules
	logic        strobe_seen;
	logic [7:0]  exp_btn; // up down left right coin start fire1 fire2
	logic        exp_up, exp_down, exp_left, exp_right, exp_fire1, exp_fire2;
	logic [7:0]  thrust_q;
	int          step_gap;
	logic        wr_seen;
	logic        exp_req;
	logic        dl_seen;
	logic        exp_loaded;
	int          since_release;

	llander_glue_top #(
		.THRUST_TICK (TICK),
		.DIFF_HOLD   (HOLD),
		.DAC_BITS    (8)
	) u_llander_glue_top (
		.i_clk_25 (clk_25), .i_arst_n (arst_n),
		.i_key_strobe (key_strobe), .i_key_pressed (key_pressed), .i_key_code (key_code),
		.i_joy0 (joy0), .i_joy1 (joy1),
		.i_ioctl_download (ioctl_download), .i_ioctl_wr (ioctl_wr),
		.i_ioctl_addr (ioctl_addr), .i_ioctl_dout (ioctl_dout),
		.i_menu_reset (menu_reset), .i_button_reset (button_reset),
		.i_cpu_rom_addr (cpu_rom_addr), .i_vector_rom_addr (vector_rom_addr),
		.i_cpu_mem_q (cpu_mem_q), .i_vector_mem_q (vector_mem_q),
		.i_lamp3 (lamp3), .i_lamp4 (lamp4), .i_lamp5 (lamp5), .i_audio (audio),
		.o_rot_left_n (o_rot_left_n), .o_rot_right_n (o_rot_right_n),
		.o_abort_n (o_abort_n), .o_game_sel_n (o_game_sel_n),
		.o_start_n (o_start_n), .o_coin_n (o_coin_n), .o_thrust (o_thrust),
		.o_port1_req (o_port1_req), .o_port2_req (o_port2_req),
		.o_port1_addr (o_port1_addr), .o_port2_addr (o_port2_addr),
		.o_port_ds (o_port_ds), .o_port_we (o_port_we), .o_port_d (o_port_d),
		.o_cpu_mem_addr (o_cpu_mem_addr), .o_vector_mem_addr (o_vector_mem_addr),
		.o_cpu_rom_data (o_cpu_rom_data), .o_vector_rom_data (o_vector_rom_data),
		.o_core_reset (o_core_reset), .o_led (o_led),
		.o_diff_show (o_diff_show), .o_difficulty (o_difficulty), .o_audio (o_audio)
	);

	initial begin
		clk_25 = 1'b0;
		forever #5 clk_25 = ~clk_25;
	end

	assign exp_up    = exp_btn[0] | joy0[3] | joy1[3];
	assign exp_down  = exp_btn[1] | joy0[2] | joy1[2];
	assign exp_left  = exp_btn[2] | joy0[1] | joy1[1];
	assign exp_right = exp_btn[3] | joy0[0] | joy1[0];
	assign exp_fire1 = exp_btn[6] | joy0[4] | joy1[4];
	assign exp_fire2 = exp_btn[7] | joy0[5] | joy1[5];

	always_ff @(posedge clk_25 or negedge arst_n) begin
		if (!arst_n) begin
			strobe_seen   <= 1'b0;
			exp_btn       <= '0;
			thrust_q      <= '0;
			step_gap      <= 0;
			wr_seen       <= 1'b0;
			exp_req       <= 1'b0;
			dl_seen       <= 1'b0;
			exp_loaded    <= 1'b0;
			since_release <= 1000;
		end else begin
			strobe_seen <= key_strobe;
			if (key_strobe != strobe_seen) begin
				case (key_code)
					KEY_UP:    exp_btn[0] <= key_pressed;
					KEY_DOWN:  exp_btn[1] <= key_pressed;
					KEY_LEFT:  exp_btn[2] <= key_pressed;
					KEY_RIGHT: exp_btn[3] <= key_pressed;
					KEY_ESC:   exp_btn[4] <= key_pressed;
					KEY_F1:    exp_btn[5] <= key_pressed;
					KEY_SPACE: exp_btn[6] <= key_pressed;
					KEY_ALT:   exp_btn[7] <= key_pressed;
					default: ;
				endcase
			end
			thrust_q <= o_thrust;
			step_gap <= (o_thrust != thrust_q) ? 1 : (step_gap < 10000 ? step_gap + 1 : step_gap);
			wr_seen <= ioctl_wr;
			if (ioctl_download && ioctl_wr && !wr_seen)
				exp_req <= ~exp_req;
			dl_seen <= ioctl_download;
			if (dl_seen && !ioctl_download)
				exp_loaded <= 1'b1;
			if (exp_fire2)
				since_release <= 0;
			else if (since_release < 1000)
				since_release <= since_release + 1;
		end
	end

	// keys lag the strobe by one cycle while sticks act at once
	a_controls: assert property (@(posedge clk_25) disable iff (!arst_n)
		o_rot_left_n == !exp_left && o_rot_right_n == !exp_right
		&& o_abort_n == !exp_fire2 && o_game_sel_n == !exp_fire1
		&& o_start_n == !exp_btn[5] && o_coin_n == !exp_btn[4])
		else begin
			errors++;
			$display("MISMATCH at %0t: cabinet controls", $time);
		end

	a_thrust_step: assert property (@(posedge clk_25) disable iff (!arst_n)
		o_thrust != thrust_q |-> step_gap >= int'(TICK) - 1
		&& (o_thrust == thrust_q + 8'd1 || o_thrust + 8'd1 == thrust_q))
		else begin
			errors++;
			$display("MISMATCH at %0t: thrust step %0d", $time, o_thrust);
		end

	a_thrust_up: assert property (@(posedge clk_25) disable iff (!arst_n)
		exp_up |=> o_thrust >= $past(o_thrust))
		else begin
			errors++;
			$display("MISMATCH at %0t: thrust fell with up held", $time);
		end

	a_thrust_down: assert property (@(posedge clk_25) disable iff (!arst_n)
		!exp_up && exp_down |=> o_thrust <= $past(o_thrust))
		else begin
			errors++;
			$display("MISMATCH at %0t: thrust rose on down", $time);
		end

	a_thrust_idle: assert property (@(posedge clk_25) disable iff (!arst_n)
		!exp_up && !exp_down |=> $stable(o_thrust))
		else begin
			errors++;
			$display("MISMATCH at %0t: thrust moved idle", $time);
		end

	a_requests: assert property (@(posedge clk_25) disable iff (!arst_n)
		o_port1_req == exp_req && o_port2_req == exp_req)
		else begin
			errors++;
			$display("MISMATCH at %0t: request toggles", $time);
		end

	a_port_map: assert property (@(posedge clk_25) disable iff (!arst_n)
		o_port1_addr == ioctl_addr[23:1] && o_port2_addr == o_port1_addr - 23'h1000
		&& o_port_ds == (ioctl_addr[0] ? 2'b10 : 2'b01) && o_port_d == {ioctl_dout, ioctl_dout}
		&& o_port_we == ioctl_download && o_led == !ioctl_download)
		else begin
			errors++;
			$display("MISMATCH at %0t: port address or data", $time);
		end

	// word address is the byte address halved, the odd byte sits in the upper half
	a_rom_read: assert property (@(posedge clk_25) disable iff (!arst_n)
		o_cpu_mem_addr == (ioctl_download ? 15'h7fff : 15'(cpu_rom_addr / 2))
		&& o_vector_mem_addr == (ioctl_download ? 15'h7fff : 15'(vector_rom_addr / 2))
		&& o_cpu_rom_data == 8'(cpu_mem_q >> (8 * cpu_rom_addr[0]))
		&& o_vector_rom_data == 8'(vector_mem_q >> (8 * vector_rom_addr[0])))
		else begin
			errors++;
			$display("MISMATCH at %0t: rom read address or data", $time);
		end

	a_load_state: assert property (@(posedge clk_25) disable iff (!arst_n)
		(u_llander_glue_top.u_rom_loader.load_state == llander_sys_pkg::LD_LOADED)
		== exp_loaded)
		else begin
			errors++;
			$display("MISMATCH at %0t: load state", $time);
		end

	a_core_reset: assert property (@(posedge clk_25) disable iff (!arst_n)
		1'b1 |=> o_core_reset == $past(menu_reset | button_reset | !exp_loaded))
		else begin
			errors++;
			$display("MISMATCH at %0t: core reset", $time);
		end

	a_diff_on: assert property (@(posedge clk_25) disable iff (!arst_n)
		since_release < int'(HOLD) - 1 |-> o_diff_show)
		else begin
			errors++;
			$display("MISMATCH at %0t: overlay dropped early", $time);
		end

	a_diff_off: assert property (@(posedge clk_25) disable iff (!arst_n)
		since_release > int'(HOLD) |-> !o_diff_show)
		else begin
			errors++;
			$display("MISMATCH at %0t: overlay held too long", $time);
		end

	a_lamps: assert property (@(posedge clk_25) disable iff (!arst_n)
		o_difficulty == (lamp5 ? 2'd3 : lamp4 ? 2'd2 : lamp3 ? 2'd1 : 2'd0))
		else begin
			errors++;
			$display("MISMATCH at %0t: difficulty lamps", $time);
		end

	`include "tb_tasks.svh"

	initial begin
		#2_000_000;
		$display("watchdog expired, the stimulus never finished");
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		key_code_e  keys [8];
		int         mark;
		int         held;
		logic [7:0] code;
		keys = '{KEY_LEFT, KEY_RIGHT, KEY_ESC, KEY_F1, KEY_SPACE, KEY_ALT, KEY_UP, KEY_DOWN};
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		void'($urandom(32'h0a38_c1a5));
		arst_n = 1'b0;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = '0;
		joy0 = '0;
		joy1 = '0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		menu_reset = 1'b0;
		button_reset = 1'b0;
		cpu_rom_addr = '0;
		vector_rom_addr = '0;
		cpu_mem_q = '0;
		vector_mem_q = '0;
		lamp3 = 1'b0;
		lamp4 = 1'b0;
		lamp5 = 1'b0;
		audio = '0;
		repeat (5) @(posedge clk_25);
		#1 arst_n = 1'b1;
		step(3);

		mark = errors;
		foreach (keys[i]) begin
			press_key(keys[i], 1'b1);
			step(3);
			press_key(keys[i], 1'b0);
			step(3);
		end
		for (int n = 0; n < 12; n++) begin
			code = pick_unmapped();
			press_key(code, 1'($urandom));
			step(2);
		end
		report_test("keyboard", mark);

		mark = errors;
		for (int b = 0; b < 6; b++) begin
			joy0 = 8'(1 << b); // one stick at a time
			step(2);
			joy0 = '0;
			joy1 = 8'(1 << b);
			step(2);
			joy1 = '0;
		end
		step(HOLD + 5);
		report_test("joystick", mark);

		mark = errors;
		press_key(KEY_UP, 1'b1);
		wait_thrust(THRUST_MAX, 3000);
		step(40);
		check_thrust(THRUST_MAX);
		press_key(KEY_DOWN, 1'b1);
		step(40);
		check_thrust(THRUST_MAX); // up wins
		press_key(KEY_UP, 1'b0);
		wait_thrust(8'd0, 3000);
		step(40);
		check_thrust(8'd0);
		press_key(KEY_UP, 1'b1);
		wait_thrust(8'd5, 200);
		press_key(KEY_UP, 1'b0);
		press_key(KEY_DOWN, 1'b0);
		report_test("thrust", mark);

		mark = errors;
		ioctl_download = 1'b1;
		step(2);
		for (int n = 0; n < 24; n++)
			write_byte(25'($urandom), 8'($urandom));
		ioctl_download = 1'b0;
		wait_core_reset_low(20);
		menu_reset = 1'b1;
		step(3);
		menu_reset = 1'b0;
		step(3);
		button_reset = 1'b1;
		step(3);
		button_reset = 1'b0;
		step(3);
		report_test("download", mark);

		mark = errors;
		for (int n = 0; n < 16; n++) begin
			ioctl_download = 1'(n % 2); // parked and live reads
			cpu_rom_addr = 13'($urandom);
			vector_rom_addr = 13'($urandom);
			cpu_mem_q = 16'($urandom);
			vector_mem_q = 16'($urandom);
			step(1);
		end
		ioctl_download = 1'b0;
		step(2);
		report_test("rom read", mark);

		mark = errors;
		press_key(KEY_ALT, 1'b1);
		step(6);
		press_key(KEY_ALT, 1'b0);
		wait_overlay_off(HOLD + 20, held);
		if (held < int'(HOLD) - 1 || held > int'(HOLD) + 2) begin
			errors++;
			$display("MISMATCH at %0t: overlay lasted %0d cycles", $time, held);
		end
		for (int l = 0; l < 8; l++) begin
			{lamp5, lamp4, lamp3} = 3'(l);
			step(2);
		end
		report_test("difficulty", mark);

		mark = errors;
		for (int n = 0; n < 6; n++)
			measure_audio(8'($urandom));
		report_test("audio", mark);

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
